//--- rtl/fb_pkg.sv
package fb_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////

    // Default address width of the memory side
    localparam int ADDR_W = 32;

    // One RGB565 style pixel, fixed by the framebuffer format
    localparam int PIXEL_W = 16;

    // One memory word holds two pixels
    localparam int DATA_W = 32;

    //////////////////////////////////////////////////
    // Stream items
    //////////////////////////////////////////////////

    // Fetch request from the rasterizer side
    typedef struct packed {
        logic [ADDR_W-1:0] index;
        logic              keep;
        logic              last;
    } fetch_t;

    // Fragment sent back with the fetched pixel
    typedef struct packed {
        logic [PIXEL_W-1:0] pixel;
        logic [ADDR_W-1:0]  dest;
        logic               keep;
        logic               last;
    } frag_t;

endpackage

//--- rtl/fetch_broadcast.sv
`timescale 1ns/1ps

module fetch_broadcast import fb_pkg::*; (
    input  logic   aclk,
    input  logic   i_rst_n,

    // Fetch stream in
    input  logic   i_valid,
    input  fetch_t i_item,
    output logic   o_ready,

    // Two copies out, each with its own ready
    output logic   o_valid0,
    input  logic   i_ready0,
    output logic   o_valid1,
    input  logic   i_ready1,
    output fetch_t o_item
);

    logic   pend0;
    logic   pend1;
    logic   pend0_next;
    logic   pend1_next;
    fetch_t item_q;

    // A pending copy clears on its own handshake
    assign pend0_next = pend0 & ~i_ready0;
    assign pend1_next = pend1 & ~i_ready1;

    // Free once nothing is left over after this cycle
    assign o_ready = ~pend0_next & ~pend1_next;

    always_ff @(posedge aclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pend0 <= 1'b0;
            pend1 <= 1'b0;
        end else if (i_valid && o_ready) begin
            pend0 <= 1'b1;
            pend1 <= 1'b1;
        end else begin
            pend0 <= pend0_next;
            pend1 <= pend1_next;
        end
    end

    always_ff @(posedge aclk) begin
        if (i_valid && o_ready) begin
            item_q <= i_item;
        end
    end

    assign o_valid0 = pend0;
    assign o_valid1 = pend1;
    assign o_item   = item_q;

endmodule

//--- rtl/fetch_fifo.sv
`timescale 1ns/1ps

module fetch_fifo #(
    parameter int WIDTH      = 34,
    parameter int DEPTH_LOG2 = 4
) (
    input  logic             aclk,
    input  logic             i_rst_n,

    // Write side
    input  logic             i_wr,
    input  logic [WIDTH-1:0] i_data,
    output logic             o_full,

    // Read side
    input  logic             i_rd,
    output logic [WIDTH-1:0] o_data,
    output logic             o_empty
);

    localparam int DEPTH = 1 << DEPTH_LOG2;

    logic [WIDTH-1:0]    mem [DEPTH];
    // Extra top bit tells a full buffer from an empty one
    logic [DEPTH_LOG2:0] wr_ptr;
    logic [DEPTH_LOG2:0] rd_ptr;
    logic                do_wr;
    logic                do_rd;

    assign o_empty = (wr_ptr == rd_ptr);
    assign o_full  = (wr_ptr[DEPTH_LOG2] != rd_ptr[DEPTH_LOG2])
                  && (wr_ptr[DEPTH_LOG2-1:0] == rd_ptr[DEPTH_LOG2-1:0]);

    assign do_wr = i_wr & ~o_full;
    assign do_rd = i_rd & ~o_empty;

    always_ff @(posedge aclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (do_wr) begin
            mem[wr_ptr[DEPTH_LOG2-1:0]] <= i_data;
        end
    end

    // Head is read without a register, visible the cycle after the write
    assign o_data = mem[rd_ptr[DEPTH_LOG2-1:0]];

endmodule

//--- rtl/read_request_gen.sv
`timescale 1ns/1ps

module read_request_gen import fb_pkg::*; #(
    parameter int ADDR_WIDTH = ADDR_W
) (
    input  logic                  aclk,
    input  logic                  i_rst_n,

    // Framebuffer base address
    input  logic [ADDR_WIDTH-1:0] i_conf_addr,

    // Fetch items
    input  logic                  i_valid,
    input  fetch_t                i_item,
    output logic                  o_ready,

    // AXI4-Lite AR channel
    output logic [ADDR_WIDTH-1:0] o_araddr,
    output logic                  o_arvalid,
    input  logic                  i_arready
);

    logic [ADDR_WIDTH-1:0] byte_off;
    logic [ADDR_WIDTH-1:0] word_addr;

    // Two bytes per pixel, then align down to the 32 bit word
    assign byte_off  = ADDR_WIDTH'(i_item.index) << 1;
    assign word_addr = (i_conf_addr + byte_off) & {{(ADDR_WIDTH-2){1'b1}}, 2'b00};

    // Free when no request is waiting or the waiting one leaves now
    assign o_ready = ~o_arvalid | i_arready;

    always_ff @(posedge aclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_arvalid <= 1'b0;
        end else if (i_valid && o_ready && i_item.keep) begin
            o_arvalid <= 1'b1;
        end else if (i_arready) begin
            o_arvalid <= 1'b0;
        end
    end

    // Dropped items (keep low) never touch the address
    always_ff @(posedge aclk) begin
        if (i_valid && o_ready && i_item.keep) begin
            o_araddr <= word_addr;
        end
    end

endmodule

//--- rtl/fb_serializer.sv
`timescale 1ns/1ps

module fb_serializer import fb_pkg::*; (
    input  logic              aclk,
    input  logic              i_rst_n,

    // Head of the fetch FIFO
    input  logic              i_valid,
    input  fetch_t            i_item,
    output logic              o_ready,

    // AXI4-Lite R channel
    input  logic [DATA_W-1:0] i_rdata,
    input  logic              i_rvalid,
    output logic              o_rready,

    // Fragment stream out
    output logic              o_frag_valid,
    output frag_t             o_frag,
    input  logic              i_frag_ready
);

    logic               out_free;
    logic               load;
    logic [PIXEL_W-1:0] pixel;
    frag_t              frag_d;
    frag_t              frag_q;
    logic               frag_valid_q;

    //////////////////////////////////////////////////
    // Join head item with read data
    //////////////////////////////////////////////////

    // Output register is empty or drains this cycle
    assign out_free = ~frag_valid_q | i_frag_ready;

    // Only kept items wait for a read beat
    assign o_rready = out_free & i_valid & i_item.keep;

    assign load = out_free & i_valid & (~i_item.keep | i_rvalid);

    // Pop the FIFO together with loading the fragment
    assign o_ready = load;

    always_comb begin
        if (!i_item.keep) begin
            pixel = '0;
        end else if (i_item.index[0]) begin
            pixel = i_rdata[DATA_W-1:PIXEL_W];
        end else begin
            pixel = i_rdata[PIXEL_W-1:0];
        end
    end

    always_comb begin
        frag_d.pixel = pixel;
        frag_d.dest  = i_item.index;
        frag_d.keep  = i_item.keep;
        frag_d.last  = i_item.last;
    end

    //////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            frag_valid_q <= 1'b0;
        end else if (load) begin
            frag_valid_q <= 1'b1;
        end else if (i_frag_ready) begin
            frag_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (load) begin
            frag_q <= frag_d;
        end
    end

    assign o_frag_valid = frag_valid_q;
    assign o_frag       = frag_q;

endmodule

//--- rtl/fb_reader.sv
`timescale 1ns/1ps

module fb_reader import fb_pkg::*; #(
    parameter int ADDR_WIDTH      = ADDR_W,
    parameter int FIFO_DEPTH_LOG2 = 4
) (
    input  logic                  aclk,
    input  logic                  i_rst_n,

    // Configuration
    input  logic [ADDR_WIDTH-1:0] i_conf_addr,

    // Fetch stream
    input  logic                  i_fetch_valid,
    input  fetch_t                i_fetch,
    output logic                  o_fetch_ready,

    // Fragment stream
    output logic                  o_frag_valid,
    output frag_t                 o_frag,
    input  logic                  i_frag_ready,

    // AXI4-Lite read channels
    output logic [ADDR_WIDTH-1:0] o_araddr,
    output logic                  o_arvalid,
    input  logic                  i_arready,
    input  logic [DATA_W-1:0]     i_rdata,
    input  logic [1:0]            i_rresp,
    input  logic                  i_rvalid,
    output logic                  o_rready
);

    localparam int FETCH_W = $bits(fetch_t);

    logic               bc_valid0;
    logic               bc_valid1;
    fetch_t             bc_item;
    logic               rq_ready;
    logic               fifo_full;
    logic               fifo_empty;
    logic [FETCH_W-1:0] fifo_data;
    fetch_t             fifo_item;
    logic               ser_ready;

    fetch_broadcast u_bcast (
        .aclk     (aclk),
        .i_rst_n  (i_rst_n),
        .i_valid  (i_fetch_valid),
        .i_item   (i_fetch),
        .o_ready  (o_fetch_ready),
        .o_valid0 (bc_valid0),
        .i_ready0 (rq_ready),
        .o_valid1 (bc_valid1),
        .i_ready1 (~fifo_full),
        .o_item   (bc_item)
    );

    fetch_fifo #(
        .WIDTH      (FETCH_W),
        .DEPTH_LOG2 (FIFO_DEPTH_LOG2)
    ) u_fifo (
        .aclk    (aclk),
        .i_rst_n (i_rst_n),
        .i_wr    (bc_valid1),
        .i_data  (FETCH_W'(bc_item)),
        .o_full  (fifo_full),
        .i_rd    (ser_ready),
        .o_data  (fifo_data),
        .o_empty (fifo_empty)
    );

    assign fifo_item = fetch_t'(fifo_data);

    read_request_gen #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_req (
        .aclk        (aclk),
        .i_rst_n     (i_rst_n),
        .i_conf_addr (i_conf_addr),
        .i_valid     (bc_valid0),
        .i_item      (bc_item),
        .o_ready     (rq_ready),
        .o_araddr    (o_araddr),
        .o_arvalid   (o_arvalid),
        .i_arready   (i_arready)
    );

    // Slave is assumed to answer OKAY, so i_rresp is not checked
    fb_serializer u_ser (
        .aclk         (aclk),
        .i_rst_n      (i_rst_n),
        .i_valid      (~fifo_empty),
        .i_item       (fifo_item),
        .o_ready      (ser_ready),
        .i_rdata      (i_rdata),
        .i_rvalid     (i_rvalid),
        .o_rready     (o_rready),
        .o_frag_valid (o_frag_valid),
        .o_frag       (o_frag),
        .i_frag_ready (i_frag_ready)
    );

endmodule

//--- dv/fb_reader_assert.sv
`timescale 1ns/1ps

module fb_reader_assert import fb_pkg::*; #(
    parameter int ADDR_WIDTH = ADDR_W
) (
    input logic                  aclk,
    input logic                  i_rst_n,
    input logic [ADDR_WIDTH-1:0] o_araddr,
    input logic                  o_arvalid,
    input logic                  i_arready,
    input logic                  o_frag_valid,
    input frag_t                 o_frag,
    input logic                  i_frag_ready
);

    // AR request holds until the slave takes it
    ar_hold_a: assert property (@(posedge aclk) disable iff (!i_rst_n)
        o_arvalid && !i_arready |=> o_arvalid && $stable(o_araddr))
        else $error("AR request changed while stalled");

    frag_hold_a: assert property (@(posedge aclk) disable iff (!i_rst_n)
        o_frag_valid && !i_frag_ready |=> o_frag_valid && $stable(o_frag))
        else $error("fragment changed while stalled");

    reset_idle_a: assert property (@(posedge aclk)
        !i_rst_n |-> !o_arvalid && !o_frag_valid)
        else $error("valid raised during reset");

endmodule

bind fb_reader fb_reader_assert #(.ADDR_WIDTH(ADDR_WIDTH)) assert_i (
    .aclk         (aclk),
    .i_rst_n      (i_rst_n),
    .o_araddr     (o_araddr),
    .o_arvalid    (o_arvalid),
    .i_arready    (i_arready),
    .o_frag_valid (o_frag_valid),
    .o_frag       (o_frag),
    .i_frag_ready (i_frag_ready)
);

//--- dv/fb_reader_tb.sv
`timescale 1ns/1ps

module fb_reader_tb import fb_pkg::*; ();

    localparam int NUM   = 12;
    localparam int LIMIT = 40 * NUM + 100;
    localparam logic [31:0] BASE0 = 32'h0001_0000;
    localparam logic [31:0] BASE1 = 32'h0008_0400;

    typedef struct packed {
        logic        base_sel;
        logic [31:0] index;
        logic        keep;
        logic        last;
    } entry_t;

    // Columns are base select, pixel index, keep, last
    localparam entry_t TBL [NUM] = '{
        '{1'b0, 32'd0,    1'b1, 1'b0},
        '{1'b0, 32'd1,    1'b1, 1'b0},
        '{1'b0, 32'd7,    1'b1, 1'b0},
        '{1'b0, 32'd4,    1'b0, 1'b0},
        '{1'b0, 32'd9,    1'b1, 1'b0},
        '{1'b0, 32'd10,   1'b1, 1'b1},
        '{1'b1, 32'd0,    1'b1, 1'b0},
        '{1'b1, 32'd1,    1'b1, 1'b0},
        '{1'b1, 32'd5,    1'b0, 1'b0},
        '{1'b1, 32'd6,    1'b1, 1'b0},
        '{1'b1, 32'd1023, 1'b1, 1'b0},
        '{1'b1, 32'd1024, 1'b1, 1'b1}
    };

    logic        aclk;
    logic        i_rst_n;
    logic [31:0] i_conf_addr;
    logic        i_fetch_valid;
    fetch_t      i_fetch;
    logic        o_fetch_ready;
    logic        o_frag_valid;
    frag_t       o_frag;
    logic        i_frag_ready;
    logic [31:0] o_araddr;
    logic        o_arvalid;
    logic        i_arready;
    logic [31:0] i_rdata;
    logic [1:0]  i_rresp;
    logic        i_rvalid;
    logic        o_rready;

    integer      seed = 32'h4570;
    int          cycles = 0;
    int          ar_count = 0;
    int          kept_count = 0;
    int          ar_delay;
    int          r_delay;
    frag_t       exp_frag_q [$];
    logic [31:0] exp_addr_q [$];
    logic [31:0] r_addr_q [$];

    fb_reader #(
        .ADDR_WIDTH      (32),
        .FIFO_DEPTH_LOG2 (4)
    ) dut_i (
        .aclk          (aclk),
        .i_rst_n       (i_rst_n),
        .i_conf_addr   (i_conf_addr),
        .i_fetch_valid (i_fetch_valid),
        .i_fetch       (i_fetch),
        .o_fetch_ready (o_fetch_ready),
        .o_frag_valid  (o_frag_valid),
        .o_frag        (o_frag),
        .i_frag_ready  (i_frag_ready),
        .o_araddr      (o_araddr),
        .o_arvalid     (o_arvalid),
        .i_arready     (i_arready),
        .i_rdata       (i_rdata),
        .i_rresp       (i_rresp),
        .i_rvalid      (i_rvalid),
        .o_rready      (o_rready)
    );

    initial begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // Word address of a pixel, two bytes per pixel
    function automatic logic [31:0] pixel_word_addr(input logic [31:0] base,
                                                    input logic [31:0] idx);
        return (base + (idx << 1)) & 32'hFFFF_FFFC;
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return addr ^ 32'hA5C3_5A3C;
    endfunction

    function automatic frag_t expected_frag(input logic [31:0] base, input entry_t e);
        logic [31:0] word;
        frag_t       f;
        word    = mem_word(pixel_word_addr(base, e.index));
        f.pixel = '0;
        if (e.keep) begin
            f.pixel = e.index[0] ? word[31:16] : word[15:0];
        end
        f.dest = e.index;
        f.keep = e.keep;
        f.last = e.last;
        return f;
    endfunction

    task automatic stop_with_error(input string msg);
        $display("ERROR at time %0t: %s", $time, msg);
        $display("test failed");
        $fatal(1, "%s", msg);
    endtask

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at time %0t: %s got %0h expected %0h", $time, name, got, exp);
            $display("test failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // Drain all outstanding fragments, then settle a few cycles
    task automatic wait_idle();
        while (exp_frag_q.size() != 0) begin
            @(posedge aclk);
        end
        repeat (3) @(posedge aclk);
        #1;
    endtask

    always @(posedge aclk) begin
        cycles++;
        if (cycles > LIMIT) begin
            stop_with_error("timeout, the DUT stopped producing fragments");
        end
    end

    //////////////////////////////////////////////////
    // AXI4-Lite read slave, fragment sink, scoreboard
    //////////////////////////////////////////////////

    initial begin
        logic  ar_fire;
        logic  r_fire;
        logic  frag_fire;
        frag_t want;
        ar_delay = rand_below(4);
        r_delay  = rand_below(4);
        forever begin
            // Handshakes are sampled mid cycle, where every signal has settled
            @(negedge aclk);
            ar_fire   = o_arvalid && i_arready;
            r_fire    = i_rvalid && o_rready;
            frag_fire = o_frag_valid && i_frag_ready;
            if (ar_fire) begin
                if (exp_addr_q.size() == 0) begin
                    stop_with_error("read issued with no kept item waiting");
                end else begin
                    compare_value("o_araddr", 64'(o_araddr), 64'(exp_addr_q.pop_front()));
                    r_addr_q.push_back(o_araddr);
                    ar_count++;
                end
            end
            if (r_fire) begin
                void'(r_addr_q.pop_front());
            end
            if (frag_fire) begin
                if (exp_frag_q.size() == 0) begin
                    stop_with_error("fragment arrived with none expected");
                end else begin
                    want = exp_frag_q.pop_front();
                    compare_value("o_frag.pixel", 64'(o_frag.pixel), 64'(want.pixel));
                    compare_value("o_frag.dest", 64'(o_frag.dest), 64'(want.dest));
                    compare_value("o_frag.keep", 64'(o_frag.keep), 64'(want.keep));
                    compare_value("o_frag.last", 64'(o_frag.last), 64'(want.last));
                end
            end
            @(posedge aclk);
            #1;
            if (ar_fire) begin
                i_arready = 1'b0;
                ar_delay  = rand_below(4);
            end
            if (o_arvalid && !i_arready) begin
                if (ar_delay == 0) begin
                    i_arready = 1'b1;
                end else begin
                    ar_delay--;
                end
            end
            if (r_fire) begin
                i_rvalid = 1'b0;
                i_rdata  = '0;
                r_delay  = rand_below(4);
            end
            // Answers leave in the order the requests came in
            if (!i_rvalid && r_addr_q.size() > 0) begin
                if (r_delay == 0) begin
                    i_rvalid = 1'b1;
                    i_rdata  = mem_word(r_addr_q[0]);
                end else begin
                    r_delay--;
                end
            end
            i_frag_ready = (rand_below(3) != 0);
        end
    end

    //////////////////////////////////////////////////
    // Fetch stimulus
    //////////////////////////////////////////////////

    initial begin
        entry_t e;
        logic   cur_sel;
        i_rst_n       = 1'b0;
        i_conf_addr   = BASE0;
        i_fetch_valid = 1'b0;
        i_fetch       = '0;
        i_frag_ready  = 1'b0;
        i_arready     = 1'b0;
        i_rdata       = '0;
        i_rresp       = 2'b00;
        i_rvalid      = 1'b0;
        cur_sel       = 1'b0;
        repeat (2) @(posedge aclk);
        #1;
        i_rst_n = 1'b1;
        for (int i = 0; i < NUM; i++) begin
            e = TBL[i];
            // Base moves only while the DUT is idle
            if (e.base_sel != cur_sel) begin
                wait_idle();
                cur_sel     = e.base_sel;
                i_conf_addr = cur_sel ? BASE1 : BASE0;
            end
            exp_frag_q.push_back(expected_frag(i_conf_addr, e));
            if (e.keep) begin
                exp_addr_q.push_back(pixel_word_addr(i_conf_addr, e.index));
                kept_count++;
            end
            i_fetch_valid = 1'b1;
            i_fetch.index = e.index;
            i_fetch.keep  = e.keep;
            i_fetch.last  = e.last;
            // Ready seen mid cycle holds up to the next rising edge
            do begin
                @(negedge aclk);
            end while (!o_fetch_ready);
            @(posedge aclk);
            #1;
            i_fetch_valid = 1'b0;
        end
        wait_idle();
        compare_value("AR transfer count", 64'(ar_count), 64'(kept_count));
        $display("test passed");
        $finish;
    end

endmodule

//--- vlog.f
rtl/fb_pkg.sv
rtl/fetch_broadcast.sv
rtl/fetch_fifo.sv
rtl/read_request_gen.sv
rtl/fb_serializer.sv
rtl/fb_reader.sv
dv/fb_reader_assert.sv
dv/fb_reader_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the framebuffer reader testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module fb_reader_tb -f vlog.f \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/Vfb_reader_tb > sim.log 2>&1 ; cat sim.log

grep -q "test failed" sim.log && { echo "FAIL"; exit 1; } || true
grep -q "test passed" sim.log && { echo "PASS"; exit 0; } \
    || { echo "FAIL: run ended without a result line"; exit 1; }
